// File: Makefile
# Verilator flow for the ROB retire subsystem
VERILATOR ?= verilator
TOP       ?= tb_rob_subsys
FILELIST  ?= rob_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: reorder_buffer.sv
// ROB core with a single occupancy counter. Writeback indices must be live and distinct per cycle.
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         flush,
  input  rob_pkg::rob_alloc_req_t                      alloc_req,
  output rob_pkg::rob_alloc_rsp_t                      alloc_rsp,
  input  rob_pkg::rob_wb_t [rob_pkg::WB_WIDTH-1:0]     wb_req,
  output rob_pkg::rob_commit_t                         commit,
  output rob_pkg::rob_idx_t                            oldest_idx
);

  // ========================================
  // Storage and pointers
  // ========================================
  rob_pkg::rob_entry_t entries [rob_pkg::ROB_DEPTH];

  rob_pkg::rob_ptr_t head_ptr;  // Wrap bit on top
  rob_pkg::rob_ptr_t tail_ptr;
  rob_pkg::rob_ptr_t occ;       // 0 to ROB_DEPTH
  rob_pkg::rob_idx_t head_idx;
  rob_pkg::rob_idx_t tail_idx;
  rob_pkg::rob_ptr_t alloc_cnt;
  rob_pkg::rob_ptr_t retire_cnt;

  rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0] head_entries;
  logic [rob_pkg::COMMIT_WIDTH-1:0]                live;
  logic [rob_pkg::COMMIT_WIDTH-1:0]                retire_valid;

  assign head_idx   = head_ptr[rob_pkg::ROB_IDX_W-1:0];
  assign tail_idx   = tail_ptr[rob_pkg::ROB_IDX_W-1:0];
  assign oldest_idx = head_idx;

  // ========================================
  // Allocation response
  // ========================================
  always_comb begin
    alloc_rsp.ready = occ <= rob_pkg::rob_ptr_t'(rob_pkg::ROB_DEPTH - rob_pkg::DECODE_WIDTH);
    for (int i = 0; i < rob_pkg::DECODE_WIDTH; i++) begin
      alloc_rsp.rob_idx[i] = rob_pkg::rob_idx_t'(tail_idx + i);  // Wraps mod depth
    end
  end

  // Slots ignored while not ready
  assign alloc_cnt = alloc_rsp.ready ?
                     rob_pkg::rob_ptr_t'($countones(alloc_req.valid)) : '0;

  // ========================================
  // Retire path
  // ========================================
  always_comb begin
    for (int i = 0; i < rob_pkg::COMMIT_WIDTH; i++) begin
      head_entries[i] = entries[rob_pkg::rob_idx_t'(head_idx + i)];
      live[i]         = occ > rob_pkg::rob_ptr_t'(i);
    end
  end

  rob_retire_select u_retire_select (
    .head_entries (head_entries),
    .live         (live),
    .retire_valid (retire_valid)
  );

  always_comb begin
    commit.valid = retire_valid;
    commit.entry = head_entries;
  end

  assign retire_cnt = rob_pkg::rob_ptr_t'($countones(retire_valid));

  // ========================================
  // Pointer and occupancy update
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      occ      <= '0;
    end else if (flush) begin  // Flushing entry retires, everything younger dropped
      head_ptr <= '0;
      tail_ptr <= '0;
      occ      <= '0;
    end else begin
      head_ptr <= head_ptr + retire_cnt;
      tail_ptr <= tail_ptr + alloc_cnt;
      occ      <= occ + alloc_cnt - retire_cnt;
    end
  end

  // ========================================
  // Entry writes
  // ========================================
  // Allocation and writeback never hit the same slot in one cycle
  always_ff @(posedge clk) begin
    if (!flush) begin
      for (int i = 0; i < rob_pkg::DECODE_WIDTH; i++) begin
        if (alloc_rsp.ready && alloc_req.valid[i]) begin
          entries[alloc_rsp.rob_idx[i]].uop       <= alloc_req.uop[i];
          entries[alloc_rsp.rob_idx[i]].complete  <= 1'b0;
          entries[alloc_rsp.rob_idx[i]].exception <= 1'b0;
          entries[alloc_rsp.rob_idx[i]].redirect  <= 1'b0;
        end
      end
      for (int i = 0; i < rob_pkg::WB_WIDTH; i++) begin
        if (wb_req[i].valid) begin  // Always accepted
          entries[wb_req[i].rob_idx].complete  <= 1'b1;
          entries[wb_req[i].rob_idx].exception <= wb_req[i].exception;
          entries[wb_req[i].rob_idx].ecode     <= wb_req[i].ecode;
          entries[wb_req[i].rob_idx].redirect  <= wb_req[i].redirect;
          entries[wb_req[i].rob_idx].info      <= wb_req[i].info;
        end
      end
    end
  end

endmodule

// File: rob_pkg.sv
// Shared ROB types. ROB_DEPTH must be a power of two that matches ROB_IDX_W.
package rob_pkg;

  // ========================================
  // Sizes
  // ========================================
  localparam int ROB_DEPTH    = 16;
  localparam int ROB_IDX_W    = 4;
  localparam int ROB_PTR_W    = ROB_IDX_W + 1;  // Index plus wrap bit
  localparam int DECODE_WIDTH = 2;
  localparam int WB_WIDTH     = 2;
  localparam int COMMIT_WIDTH = 2;
  localparam int XLEN         = 32;
  localparam int ECODE_W      = 6;
  localparam int CNT_W        = 32;

  localparam logic [XLEN-1:0] EXC_VECTOR = 32'h0000_0800;  // Trap handler entry

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [ROB_PTR_W-1:0] rob_ptr_t;
  typedef logic [CNT_W-1:0]     rob_cnt_t;

  typedef enum logic [1:0] {
    instr_alu = 2'd0,
    instr_br  = 2'd1,
    instr_mem = 2'd2
  } instr_type_e;

  // ========================================
  // Entry and port structs
  // ========================================
  // Writeback info word, meaning set by the redirect and exception flags
  typedef union packed {
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] bad_vaddr;
  } rob_info_u;

  typedef struct packed {
    instr_type_e     instr_type;
    logic            is_store;
    logic [XLEN-1:0] pc;
  } rob_uop_t;

  typedef struct packed {
    rob_uop_t           uop;
    logic               complete;
    logic               exception;
    logic [ECODE_W-1:0] ecode;
    logic               redirect;
    rob_info_u          info;
  } rob_entry_t;

  typedef struct packed {
    logic [DECODE_WIDTH-1:0]     valid;  // Contiguous from slot 0
    rob_uop_t [DECODE_WIDTH-1:0] uop;
  } rob_alloc_req_t;

  typedef struct packed {
    logic                        ready;
    rob_idx_t [DECODE_WIDTH-1:0] rob_idx;
  } rob_alloc_rsp_t;

  typedef struct packed {
    logic               valid;
    rob_idx_t           rob_idx;
    logic               exception;
    logic [ECODE_W-1:0] ecode;
    logic               redirect;
    rob_info_u          info;
  } rob_wb_t;

  typedef struct packed {
    logic [COMMIT_WIDTH-1:0]       valid;
    rob_entry_t [COMMIT_WIDTH-1:0] entry;
  } rob_commit_t;

  typedef struct packed {
    logic               valid;
    logic               is_exception;
    logic [XLEN-1:0]    pc;
    logic [ECODE_W-1:0] ecode;
    logic [XLEN-1:0]    bad_vaddr;
  } rob_redirect_t;

  // A store is a memory op with the store flag set
  function automatic logic is_store_op(rob_uop_t uop);
    return (uop.instr_type == instr_mem) && uop.is_store;
  endfunction

endpackage

// File: rob_props.sv
// Concurrent checks on rob_subsys outputs, bound in. Assumes COMMIT_WIDTH of 2.
`timescale 1ns/1ps

module rob_props (
  input logic                   clk,
  input logic                   rst_n,
  input rob_pkg::rob_commit_t   commit,
  input rob_pkg::rob_redirect_t redirect
);

  // Flush empties the ROB so no report can follow a report
  redirect_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    redirect.valid |=> !redirect.valid)
    else $error("redirect valid held longer than one cycle");

  commit_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
    !(commit.valid[1] && !commit.valid[0]))
    else $error("commit slot 1 valid without slot 0");

  commit_idle_after_reset: assert property (@(posedge clk)
    !rst_n |=> (commit.valid == '0))
    else $error("commit valid in the cycle after reset");

  no_store_in_slot1: assert property (@(posedge clk) disable iff (!rst_n)
    !(commit.valid[1] && commit.entry[1].uop.is_store &&
      commit.entry[1].uop.instr_type == rob_pkg::instr_mem))
    else $error("store retired from slot 1");

endmodule

bind rob_subsys rob_props rob_props_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .commit   (commit),
  .redirect (redirect)
);

// File: rob_redirect_ctrl.sv
// Flush is combinational from commit and the report follows one cycle later. Exception wins over redirect.
`timescale 1ns/1ps

module rob_redirect_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rob_pkg::rob_commit_t   commit,
  output logic                   flush,
  output rob_pkg::rob_redirect_t redirect,
  output rob_pkg::rob_cnt_t      instret
);

  rob_pkg::rob_entry_t flush_entry;
  rob_pkg::rob_cnt_t   retire_cnt;

  logic                        rpt_valid;
  logic                        rpt_is_exc;
  logic [rob_pkg::XLEN-1:0]    rpt_pc;
  logic [rob_pkg::ECODE_W-1:0] rpt_ecode;
  logic [rob_pkg::XLEN-1:0]    rpt_vaddr;

  // The group-ending entry is always the last valid slot
  always_comb begin
    flush       = 1'b0;
    flush_entry = commit.entry[0];
    for (int i = 0; i < rob_pkg::COMMIT_WIDTH; i++) begin
      if (commit.valid[i] && (commit.entry[i].redirect || commit.entry[i].exception)) begin
        flush       = 1'b1;
        flush_entry = commit.entry[i];
      end
    end
  end

  assign retire_cnt = rob_pkg::rob_cnt_t'($countones(commit.valid));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rpt_valid <= 1'b0;
      instret   <= '0;
    end else begin
      rpt_valid <= flush;  // One-cycle pulse
      instret   <= instret + retire_cnt;
    end
  end

  // Report payload, info word read by entry kind
  always_ff @(posedge clk) begin
    if (flush) begin
      rpt_is_exc <= flush_entry.exception;
      rpt_pc     <= flush_entry.exception ? rob_pkg::EXC_VECTOR : flush_entry.info.br_target;
      rpt_ecode  <= flush_entry.ecode;
      rpt_vaddr  <= flush_entry.info.bad_vaddr;
    end
  end

  always_comb begin
    redirect.valid        = rpt_valid;
    redirect.is_exception = rpt_is_exc;
    redirect.pc           = rpt_pc;
    redirect.ecode        = rpt_ecode;
    redirect.bad_vaddr    = rpt_vaddr;
  end

endmodule

// File: rob_retire_select.sv
// Pure combinational retire rules. Slot 0 must be the oldest entry and live must be a prefix mask.
`timescale 1ns/1ps

module rob_retire_select (
  input  rob_pkg::rob_entry_t [rob_pkg::COMMIT_WIDTH-1:0] head_entries,
  input  logic [rob_pkg::COMMIT_WIDTH-1:0]                live,
  output logic [rob_pkg::COMMIT_WIDTH-1:0]                retire_valid
);

  logic [rob_pkg::COMMIT_WIDTH-1:0] done;        // Live and written back
  logic [rob_pkg::COMMIT_WIDTH-1:0] ends_group;  // Redirect or exception
  logic [rob_pkg::COMMIT_WIDTH-1:0] is_br;
  logic [rob_pkg::COMMIT_WIDTH-1:1] blocked;     // Oldest slot is never held by group rules

  // ========================================
  // Per-slot attributes
  // ========================================
  always_comb begin
    for (int i = 0; i < rob_pkg::COMMIT_WIDTH; i++) begin
      done[i]       = live[i] & head_entries[i].complete;
      ends_group[i] = head_entries[i].redirect | head_entries[i].exception;
      is_br[i]      = head_entries[i].uop.instr_type == rob_pkg::instr_br;
    end
  end

  // ========================================
  // Group rules
  // ========================================
  always_comb begin
    logic br_seen;
    logic stop_seen;
    br_seen   = is_br[0];
    stop_seen = ends_group[0];
    for (int i = 1; i < rob_pkg::COMMIT_WIDTH; i++) begin
      // Older flush, store off slot 0, or second branch
      blocked[i] = stop_seen | rob_pkg::is_store_op(head_entries[i].uop) |
                   (br_seen & is_br[i]);
      br_seen    = br_seen | is_br[i];
      stop_seen  = stop_seen | ends_group[i];
    end
  end

  // A slot retires only behind older retiring slots
  always_comb begin
    retire_valid[0] = done[0];
    for (int i = 1; i < rob_pkg::COMMIT_WIDTH; i++) begin
      retire_valid[i] = retire_valid[i-1] & done[i] & ~blocked[i];
    end
  end

endmodule

// File: rob_subsys.f
rob_pkg.sv
rob_retire_select.sv
reorder_buffer.sv
rob_redirect_ctrl.sv
rob_subsys.sv
rob_props.sv
tb_rob_subsys.sv

// File: rob_subsys.sv
// Retire-side top level. Inputs follow level and strobe rules with ready as the only back-pressure.
`timescale 1ns/1ps

module rob_subsys (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  rob_pkg::rob_alloc_req_t                  alloc_req,
  output rob_pkg::rob_alloc_rsp_t                  alloc_rsp,
  input  rob_pkg::rob_wb_t [rob_pkg::WB_WIDTH-1:0] wb_req,
  output rob_pkg::rob_commit_t                     commit,
  output rob_pkg::rob_redirect_t                   redirect,
  output rob_pkg::rob_cnt_t                        instret,
  output rob_pkg::rob_idx_t                        oldest_idx
);

  logic flush;  // Same-edge flush from the retiring group

  reorder_buffer u_rob (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .alloc_req  (alloc_req),
    .alloc_rsp  (alloc_rsp),
    .wb_req     (wb_req),
    .commit     (commit),
    .oldest_idx (oldest_idx)
  );

  // Watches the commit port it is fed back from
  rob_redirect_ctrl u_redirect_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .commit   (commit),
    .flush    (flush),
    .redirect (redirect),
    .instret  (instret)
  );

endmodule

// File: tb_rob_subsys.sv
// Self-checking testbench for rob_subsys. Seeded random run of about 2000 cycles, fixed phase order.
`timescale 1ns/1ps

module tb_rob_subsys;

  localparam int PHASE_CYCLES = 500;
  localparam int TOTAL_CYCLES = 4 * PHASE_CYCLES;

  logic                                     clk;
  logic                                     rst_n;
  rob_pkg::rob_alloc_req_t                  alloc_req;
  rob_pkg::rob_alloc_rsp_t                  alloc_rsp;
  rob_pkg::rob_wb_t [rob_pkg::WB_WIDTH-1:0] wb_req;
  rob_pkg::rob_commit_t                     commit;
  rob_pkg::rob_redirect_t                   redirect;
  rob_pkg::rob_cnt_t                        instret;
  rob_pkg::rob_idx_t                        oldest_idx;

  integer seed;

  // ========================================
  // Reference model state
  // ========================================
  rob_pkg::rob_entry_t              model_q[$];  // Live entries, oldest first
  rob_pkg::rob_idx_t                model_head;
  rob_pkg::rob_cnt_t                model_instret;
  rob_pkg::rob_redirect_t           exp_redirect;
  logic [rob_pkg::COMMIT_WIDTH-1:0] exp_valid;    // Group expected this cycle
  int                               wb_pos [rob_pkg::WB_WIDTH];  // Queue slot per port
  int errors;
  int phase_errors;
  int tests_run;
  int tests_failed;
  int flush_count;

  rob_subsys rob_subsys_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_req  (alloc_req),
    .alloc_rsp  (alloc_rsp),
    .wb_req     (wb_req),
    .commit     (commit),
    .redirect   (redirect),
    .instret    (instret),
    .oldest_idx (oldest_idx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic flag_mismatch(string msg);
    $display("mismatch at %0d ns: %s", $time, msg);
    errors++;
    phase_errors++;
  endtask

  // ========================================
  // Output checks against the model
  // ========================================
  task automatic check_outputs();
    int n;
    n = model_q.size();
    exp_valid = '0;
    if (n > 0 && model_q[0].complete) exp_valid[0] = 1'b1;
    // Second slot: no older flush, no store, no branch pair
    if (exp_valid[0] && n > 1 && model_q[1].complete &&
        !model_q[0].redirect && !model_q[0].exception && !model_q[1].uop.is_store &&
        !(model_q[0].uop.instr_type == rob_pkg::instr_br &&
          model_q[1].uop.instr_type == rob_pkg::instr_br))
      exp_valid[1] = 1'b1;
    if (commit.valid !== exp_valid)
      flag_mismatch($sformatf("commit valid %b, expected %b", commit.valid, exp_valid));
    for (int i = 0; i < rob_pkg::COMMIT_WIDTH; i++) begin
      if (exp_valid[i] && commit.entry[i] !== model_q[i])
        flag_mismatch($sformatf("slot %0d entry %h, expected %h", i, commit.entry[i],
                                model_q[i]));
    end
    if (alloc_rsp.ready !== (n <= rob_pkg::ROB_DEPTH - rob_pkg::DECODE_WIDTH))
      flag_mismatch($sformatf("ready %b with %0d live entries", alloc_rsp.ready, n));
    for (int s = 0; s < rob_pkg::DECODE_WIDTH; s++) begin
      if (alloc_rsp.rob_idx[s] !== rob_pkg::rob_idx_t'(model_head + n + s))
        flag_mismatch($sformatf("rob_idx[%0d] %0d, expected %0d", s, alloc_rsp.rob_idx[s],
                                rob_pkg::rob_idx_t'(model_head + n + s)));
    end
    if (oldest_idx !== model_head)
      flag_mismatch($sformatf("oldest_idx %0d, expected %0d", oldest_idx, model_head));
    if (redirect.valid !== exp_redirect.valid) begin
      flag_mismatch($sformatf("redirect valid %b, expected %b", redirect.valid,
                              exp_redirect.valid));
    end else if (exp_redirect.valid) begin
      if (redirect.is_exception !== exp_redirect.is_exception ||
          redirect.pc !== exp_redirect.pc)
        flag_mismatch($sformatf("redirect exc %b pc %h, expected exc %b pc %h",
                                redirect.is_exception, redirect.pc,
                                exp_redirect.is_exception, exp_redirect.pc));
      if (exp_redirect.is_exception && (redirect.ecode !== exp_redirect.ecode ||
          redirect.bad_vaddr !== exp_redirect.bad_vaddr))
        flag_mismatch($sformatf("exception ecode %h vaddr %h, expected %h %h",
                                redirect.ecode, redirect.bad_vaddr,
                                exp_redirect.ecode, exp_redirect.bad_vaddr));
    end
    if (instret !== model_instret)
      flag_mismatch($sformatf("instret %0d, expected %0d", instret, model_instret));
  endtask

  // ========================================
  // Stimulus, driven on the falling edge
  // ========================================
  task automatic drive_inputs(int exc_pct, int redir_pct, int wb_max);
    int          n_alloc;
    int          n_wb;
    int          t;
    int          j;
    int          cand[$];
    logic [31:0] rw;
    n_alloc = (model_q.size() <= rob_pkg::ROB_DEPTH - rob_pkg::DECODE_WIDTH) ?
              rand_below(3) : 0;  // Held back while not ready
    alloc_req = '0;
    for (int s = 0; s < rob_pkg::DECODE_WIDTH; s++) begin
      t  = rand_below(3);
      rw = $random(seed);
      alloc_req.valid[s]          = s < n_alloc;
      alloc_req.uop[s].instr_type = (t == 0) ? rob_pkg::instr_alu :
                                    (t == 1) ? rob_pkg::instr_br : rob_pkg::instr_mem;
      alloc_req.uop[s].is_store   = (t == 2) && rw[0];
      alloc_req.uop[s].pc         = {rw[31:2], 2'b00};
    end
    wb_req = '0;
    for (int k = 0; k < model_q.size(); k++) begin
      if (!model_q[k].complete) cand.push_back(k);
    end
    n_wb = rand_below(wb_max + 1);
    for (int p = 0; p < rob_pkg::WB_WIDTH; p++) begin
      wb_pos[p] = -1;
      if (p < n_wb && cand.size() > 0) begin
        j         = rand_below(cand.size());
        wb_pos[p] = cand[j];
        cand.delete(j);  // Ports stay distinct
        rw = $random(seed);
        wb_req[p].valid     = 1'b1;
        wb_req[p].rob_idx   = rob_pkg::rob_idx_t'(model_head + wb_pos[p]);
        wb_req[p].exception = rand_below(100) < exc_pct;
        wb_req[p].redirect  = !wb_req[p].exception && rand_below(100) < redir_pct &&
                              model_q[wb_pos[p]].uop.instr_type == rob_pkg::instr_br;
        wb_req[p].info      = rw;
        rw = $random(seed);
        wb_req[p].ecode     = rw[5:0];
      end
    end
  endtask

  // Applied after the rising edge, mirrors what the DUT took in
  task automatic update_model();
    rob_pkg::rob_entry_t e;
    rob_pkg::rob_entry_t last;
    int                  ret_n;
    logic                flushing;
    ret_n    = $countones(exp_valid);
    flushing = 1'b0;
    last     = '0;
    for (int i = 0; i < ret_n; i++) begin
      if (model_q[i].redirect || model_q[i].exception) begin
        flushing = 1'b1;
        last     = model_q[i];
      end
    end
    model_instret += ret_n;
    exp_redirect   = '0;
    if (flushing) begin  // Younger entries and this cycle's inputs are dropped
      exp_redirect.valid        = 1'b1;
      exp_redirect.is_exception = last.exception;
      exp_redirect.pc           = last.exception ? rob_pkg::EXC_VECTOR : last.info.br_target;
      exp_redirect.ecode        = last.ecode;
      exp_redirect.bad_vaddr    = last.info.bad_vaddr;
      model_q.delete();
      model_head = '0;
      flush_count++;
    end else begin
      for (int p = 0; p < rob_pkg::WB_WIDTH; p++) begin
        if (wb_pos[p] >= 0) begin
          e           = model_q[wb_pos[p]];
          e.complete  = 1'b1;
          e.exception = wb_req[p].exception;
          e.ecode     = wb_req[p].ecode;
          e.redirect  = wb_req[p].redirect;
          e.info      = wb_req[p].info;
          model_q[wb_pos[p]] = e;
        end
      end
      repeat (ret_n) void'(model_q.pop_front());
      model_head = rob_pkg::rob_idx_t'(model_head + ret_n);
      for (int s = 0; s < rob_pkg::DECODE_WIDTH; s++) begin
        if (alloc_req.valid[s]) begin
          e     = '0;
          e.uop = alloc_req.uop[s];
          model_q.push_back(e);
        end
      end
    end
  endtask

  task automatic run_phase(string name, int exc_pct, int redir_pct, int wb_max);
    int                flushes_before;
    rob_pkg::rob_cnt_t retired_before;
    phase_errors   = 0;
    flushes_before = flush_count;
    retired_before = model_instret;
    repeat (PHASE_CYCLES) begin
      @(negedge clk);
      check_outputs();
      drive_inputs(exc_pct, redir_pct, wb_max);
      @(posedge clk);
      update_model();
    end
    tests_run++;
    if (phase_errors != 0) tests_failed++;
    $display("test %s: %s, %0d retired, %0d flushes, %0d errors", name,
             (phase_errors == 0) ? "passed" : "failed", model_instret - retired_before,
             flush_count - flushes_before, phase_errors);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    seed          = 32'h6d8a;
    rst_n         = 1'b0;
    alloc_req     = '0;
    wb_req        = '0;
    model_head    = '0;
    model_instret = '0;
    exp_redirect  = '0;
    exp_valid     = '0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    flush_count   = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    run_phase("retire_order", 0, 0, 1);  // Slow writeback fills the ROB
    run_phase("branch_redirect", 0, 5, 2);
    run_phase("exceptions", 3, 0, 2);
    run_phase("mixed", 3, 5, 2);
    @(negedge clk);
    phase_errors = 0;
    check_outputs();
    alloc_req = '0;
    wb_req    = '0;
    if (instret !== model_instret)
      flag_mismatch($sformatf("final instret %0d, expected %0d", instret, model_instret));
    tests_run++;
    if (phase_errors != 0) tests_failed++;
    $display("test final_count: %s, instret %0d", (phase_errors == 0) ? "passed" : "failed",
             instret);
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Run limit of 1.5 clock periods per planned cycle
  initial begin
    #(TOTAL_CYCLES * 150);
    $display("watchdog expired at %0d ns before the tests finished", $time);
    $display("TEST FAIL");
    $finish;
  end

endmodule
